//--- sources.f
rtl/saturn_bus_pkg.sv
rtl/saturn_map_pkg.sv
rtl/saturn_bus_controller.sv
rtl/saturn_rom.sv
rtl/saturn_sysram.sv
rtl/saturn_mmio.sv
rtl/saturn_bus.sv
verification/saturn_bus_sva.sv
verification/tb_saturn_bus.sv

//--- Makefile
TOP := tb_saturn_bus

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_saturn_bus.sv
// ----------------------------------------------------------------------
// testbench for the saturn nibble bus
// clock, reset, lcg, stimulus table built from a device model
// check task, per test lines and closing counts
// ----------------------------------------------------------------------
module tb_saturn_bus
    import saturn_bus_pkg::*;
    import saturn_map_pkg::*;
();

    localparam int TIMEOUT = 2000;  // clocks allowed per wait

    // one host request with what it should return
    typedef struct packed {
        host_op_t               op;
        logic [ADDR_W-1:0]      addr;
        logic [COUNT_W-1:0]     count;
        logic [XFER_DATA_W-1:0] wdata;
        logic [XFER_DATA_W-1:0] exp;
        logic [7:0]             delay;  // clocks with rsp ready held low
    } row_t;

    logic                   i_clk = 1'b0;
    logic                   i_reset = 1'b1;
    logic                   i_clk_en = 1'b0;
    logic                   i_cmd_valid;
    logic                   o_cmd_ready;
    host_op_t               i_cmd_op;
    logic [ADDR_W-1:0]      i_cmd_addr;
    logic [COUNT_W-1:0]     i_cmd_count;
    logic [XFER_DATA_W-1:0] i_cmd_data;
    logic                   o_rsp_valid;
    logic                   i_rsp_ready;
    logic [XFER_DATA_W-1:0] o_rsp_data;
    logic [PHASE_W-1:0]     o_phase;
    logic [CYCLE_W-1:0]     o_cycle_ctr;

    row_t                rows[$];
    logic [NIBBLE_W-1:0] ram_m [SYSRAM_NIBBLES];  // expected device contents
    logic [NIBBLE_W-1:0] mmio_m [MMIO_NIBBLES];
    logic [ADDR_W-1:0]   ram_base;
    logic [ADDR_W-1:0]   mmio_base;
    logic                ram_cfg;
    logic                mmio_cfg;
    logic [31:0]         lcg_state = 32'h5d82fcad;
    logic [PHASE_W-1:0]  exp_phase = '0;
    logic [CYCLE_W-1:0]  exp_ctr = '0;
    logic                timed_out = 1'b0;
    int                  err_cnt = 0;
    int                  ctr_errs = 0;  // phase and counter mismatches
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;
    int                  neg_cnt = 0;

    saturn_bus uut (.*);

    initial forever #2 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_equal(input logic [XFER_DATA_W-1:0] got,
                               input logic [XFER_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    // rom by default, sysram over it, mmio over both
    function automatic logic [NIBBLE_W-1:0] model_read(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0]   ro;
        logic [ADDR_W-1:0]   mo;
        logic [NIBBLE_W-1:0] n;
        ro = a - ram_base;
        mo = a - mmio_base;
        n  = rom_nibble(a);
        if (ram_cfg && ro < ADDR_W'(SYSRAM_NIBBLES)) n = ram_m[ro[SYSRAM_IDX_W-1:0]];
        if (mmio_cfg && mo < ADDR_W'(MMIO_NIBBLES))
            n = (mo == '0) ? ~mmio_m[0] : mmio_m[mo[MMIO_IDX_W-1:0]];  // status reads inverted
        return n;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [NIBBLE_W-1:0] n);
        logic [ADDR_W-1:0] ro;
        logic [ADDR_W-1:0] mo;
        ro = a - ram_base;
        mo = a - mmio_base;
        if (ram_cfg && ro < ADDR_W'(SYSRAM_NIBBLES)) ram_m[ro[SYSRAM_IDX_W-1:0]] = n;
        if (mmio_cfg && mo < ADDR_W'(MMIO_NIBBLES)) mmio_m[mo[MMIO_IDX_W-1:0]] = n;  // overlap hits both
    endtask

    // append one request, the model gives its expected response
    task automatic add_row(input host_op_t op, input logic [ADDR_W-1:0] addr,
                           input int nibs, input int delay);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.count = COUNT_W'(nibs - 1);
        r.wdata = {lcg_next(), lcg_next()};
        r.exp   = '0;  // writes and configures answer zero
        r.delay = 8'(delay);
        case (op)
            OP_WRITE:
                for (int k = 0; k < nibs; k++)
                    model_write(addr + ADDR_W'(k), r.wdata[k*NIBBLE_W +: NIBBLE_W]);
            OP_READ:
                for (int k = 0; k < nibs; k++)
                    r.exp[k*NIBBLE_W +: NIBBLE_W] = model_read(addr + ADDR_W'(k));
            OP_CONFIG: begin
                if (!mmio_cfg) begin  // head of the daisy chain
                    mmio_cfg  = 1'b1;
                    mmio_base = addr;
                end else if (!ram_cfg) begin
                    ram_cfg  = 1'b1;
                    ram_base = addr;
                end
            end
            default: begin
                ram_cfg  = 1'b0;
                mmio_cfg = 1'b0;
            end
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(OP_READ, 20'h00000, 16, 0);  // plain rom after reset
        add_row(OP_READ, 20'h12345, 16, 0);
        add_row(OP_WRITE, 20'h00100, 8, 0);  // rom ignores this
        add_row(OP_READ, 20'h00100, 8, 0);
        add_row(OP_CONFIG, 20'h40000, 1, 0);  // mmio
        add_row(OP_CONFIG, 20'h20000, 1, 0);  // sysram
        add_row(OP_WRITE, 20'h20000, 16, 0);
        add_row(OP_READ, 20'h20000, 16, 0);
        add_row(OP_WRITE, 20'h20010, 16, 0);
        add_row(OP_WRITE, 20'h200f0, 16, 0);
        add_row(OP_READ, 20'h1fff8, 16, 0);  // rom below, ram above
        add_row(OP_READ, 20'h200f8, 16, 0);  // ram then rom past the top
        add_row(OP_WRITE, 20'h40000, 16, 0);
        add_row(OP_READ, 20'h40000, 16, 0);
        add_row(OP_UNCONFIG, 20'h00000, 1, 0);
        add_row(OP_CONFIG, 20'h20020, 1, 0);  // mmio inside the ram window
        add_row(OP_CONFIG, 20'h20000, 1, 0);
        add_row(OP_WRITE, 20'h20020, 16, 0);
        add_row(OP_READ, 20'h20018, 16, 0);  // overlap goes to mmio
        add_row(OP_READ, 20'h20000, 16, 0);
        add_row(OP_READ, 20'h200f0, 16, 0);
        add_row(OP_UNCONFIG, 20'h00000, 1, 0);
        add_row(OP_READ, 20'h20018, 16, 0);  // rom again
        add_row(OP_READ, 20'h40000, 16, 0);
        add_row(OP_CONFIG, 20'h30000, 1, 0);  // mmio comes first again
        add_row(OP_READ, 20'h30000, 16, 0);
        add_row(OP_READ, 20'h30000, 16, 6);  // host stalls the response
        add_row(OP_WRITE, 20'h30004, 4, 5);
        add_row(OP_READ, 20'h30000, 8, 0);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_row(input int n);
        row_t                   r;
        host_op_t               op;
        int                     t;
        int                     start_errs;
        logic [XFER_DATA_W-1:0] held;
        r          = rows[n];
        op         = r.op;
        start_errs = err_cnt;
        t = 0;
        while (!o_cmd_ready && t < TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        if (!o_cmd_ready) begin
            $display("test %0d timed out waiting for the controller to accept a request", n);
            timed_out = 1'b1;
            return;
        end
        i_cmd_valid = 1'b1;
        i_cmd_op    = r.op;
        i_cmd_addr  = r.addr;
        i_cmd_count = r.count;
        i_cmd_data  = r.wdata;
        i_rsp_ready = (r.delay == 8'd0);
        @(negedge i_clk);  // taken on the rising edge just passed
        i_cmd_valid = 1'b0;
        t = 0;
        while (!o_rsp_valid && t < TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        if (!o_rsp_valid) begin
            $display("test %0d timed out waiting for a response", n);
            timed_out = 1'b1;
            return;
        end
        check_equal(o_rsp_data, r.exp, "response data");
        held = o_rsp_data;
        for (int d = 0; d < int'(r.delay); d++) begin
            @(negedge i_clk);
            check_equal(o_rsp_valid, 1, "response valid while stalled");
            check_equal(o_cmd_ready, 0, "cmd ready while stalled");
            check_equal(o_rsp_data, held, "response data while stalled");
        end
        i_rsp_ready = 1'b1;
        @(negedge i_clk);
        check_equal(o_rsp_valid, 0, "response valid after handshake");
        if (err_cnt == start_errs) begin
            pass_cnt++;
            $display("test %0d %s addr %05h passed", n, op.name(), r.addr);
        end else begin
            fail_cnt++;
            $display("test %0d %s addr %05h failed, %0d errors", n, op.name(), r.addr,
                     err_cnt - start_errs);
        end
    endtask

    // reset release, clock enable and the phase ring model, all on falling edges
    always @(negedge i_clk) begin
        int errs_before;
        errs_before = err_cnt;
        check_equal(o_phase, exp_phase, "phase");
        check_equal(o_cycle_ctr, exp_ctr, "cycle counter");
        ctr_errs = ctr_errs + (err_cnt - errs_before);
        if (neg_cnt == 1) i_reset = 1'b0;  // two rising edges in reset
        neg_cnt++;
        i_clk_en = (lcg_next() >> 30) != 32'd0;  // high about 3 of 4
        if (i_reset) begin
            exp_phase = '0;
            exp_ctr   = '0;
        end else if (i_clk_en) begin
            if (exp_phase == PHASE_W'(PHASES - 1)) begin
                exp_phase = '0;
                exp_ctr   = exp_ctr + 1;  // wrap from phase 3
            end else begin
                exp_phase = exp_phase + 1'b1;
            end
        end
    end

    initial begin
        int t;
        i_cmd_valid = 1'b0;
        i_cmd_op    = OP_READ;
        i_cmd_addr  = '0;
        i_cmd_count = '0;
        i_cmd_data  = '0;
        i_rsp_ready = 1'b1;
        ram_cfg     = 1'b0;
        mmio_cfg    = 1'b0;
        ram_base    = '0;
        mmio_base   = '0;
        build_table();
        t = 0;
        while (i_reset && t < TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        @(negedge i_clk);
        check_equal(o_cmd_ready, 1, "cmd ready after reset");
        check_equal(o_rsp_valid, 0, "response valid after reset");
        for (int n = 0; n < rows.size() && !timed_out; n++)
            run_row(n);
        $display("phase and cycle counter %s, %0d errors", (ctr_errs == 0) ? "passed" : "failed",
                 ctr_errs);
        $display("tests %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/saturn_bus_sva.sv
// ----------------------------------------------------------------------
// bus and host handshake assertions
// bound into the saturn bus top level
// ----------------------------------------------------------------------
module saturn_bus_sva
    import saturn_bus_pkg::*;
(
    input logic                   i_clk,
    input logic                   i_reset,
    input logic                   i_clk_en,
    input logic                   i_bus_strobe,
    input logic [PHASE_W-1:0]     i_phase,
    input logic                   i_cmd_ready,
    input logic                   i_rsp_valid,
    input logic                   i_rsp_ready,
    input logic [XFER_DATA_W-1:0] i_rsp_data
);

    // response frozen until the host takes it
    rsp_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp_data))
        else $error("response changed before the host took it");

    // nibbles move only on a bus tick
    strobe_on_tick: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_strobe |-> i_clk_en && i_phase == PHASE_W'(PHASES - 1))
        else $error("bus strobe outside phase 3 or with clock enable low");

    ready_or_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_cmd_ready && i_rsp_valid))
        else $error("cmd ready and response valid high together");

endmodule

bind saturn_bus saturn_bus_sva u_sva (
    .i_clk(i_clk), .i_reset(i_reset), .i_clk_en(i_clk_en), .i_bus_strobe(bus_strobe),
    .i_phase(o_phase), .i_cmd_ready(o_cmd_ready), .i_rsp_valid(o_rsp_valid),
    .i_rsp_ready(i_rsp_ready), .i_rsp_data(o_rsp_data)
);

//--- rtl/saturn_bus.sv
// ----------------------------------------------------------------------
// saturn nibble bus top level
// phase ring, cycle counter, read priority mux
// controller, rom, sysram and mmio instances
// ----------------------------------------------------------------------
module saturn_bus
    import saturn_bus_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_clk_en,
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  host_op_t               i_cmd_op,
    input  logic [ADDR_W-1:0]      i_cmd_addr,
    input  logic [COUNT_W-1:0]     i_cmd_count,
    input  logic [XFER_DATA_W-1:0] i_cmd_data,
    output logic                   o_rsp_valid,
    input  logic                   i_rsp_ready,
    output logic [XFER_DATA_W-1:0] o_rsp_data,
    output logic [PHASE_W-1:0]     o_phase,
    output logic [CYCLE_W-1:0]     o_cycle_ctr
);

    logic [PHASES-1:0]   phases;  // one-hot ring
    logic                bus_tick;
    logic                bus_strobe;
    logic                bus_is_data;
    logic [NIBBLE_W-1:0] ctrl_nibble;  // controller to devices
    logic [NIBBLE_W-1:0] rd_nibble;    // devices to controller
    logic [NIBBLE_W-1:0] rom_nibble_out;
    logic [NIBBLE_W-1:0] sysram_nibble;
    logic [NIBBLE_W-1:0] mmio_nibble;
    logic                sysram_active;
    logic                mmio_active;
    logic                mmio_daisy;

    assign bus_tick = i_clk_en && phases[PHASES-1];  // last phase of the cycle

    // ring steps only with clock enable, counter bumps on the wrap
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases      <= {{(PHASES-1){1'b0}}, 1'b1};
            o_cycle_ctr <= '0;
        end else if (i_clk_en) begin
            phases      <= {phases[PHASES-2:0], phases[PHASES-1]};
            o_cycle_ctr <= o_cycle_ctr + {{(CYCLE_W-1){1'b0}}, phases[PHASES-1]};
        end
    end

    always_comb begin
        o_phase = '0;
        for (int p = 1; p < PHASES; p++)
            if (phases[p]) o_phase = PHASE_W'(p);  // one-hot to binary
    end

    // rom is the fallback, last active device wins
    always_comb begin
        rd_nibble = rom_nibble_out;
        if (sysram_active) rd_nibble = sysram_nibble;
        if (mmio_active)   rd_nibble = mmio_nibble;
    end

    saturn_bus_controller u_ctrl (
        .i_clk(i_clk), .i_reset(i_reset), .i_bus_tick(bus_tick),
        .i_cmd_valid(i_cmd_valid), .o_cmd_ready(o_cmd_ready), .i_cmd_op(i_cmd_op),
        .i_cmd_addr(i_cmd_addr), .i_cmd_count(i_cmd_count), .i_cmd_data(i_cmd_data),
        .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready), .o_rsp_data(o_rsp_data),
        .o_bus_strobe(bus_strobe), .o_bus_is_data(bus_is_data),
        .o_bus_nibble(ctrl_nibble), .i_bus_nibble(rd_nibble)
    );

    saturn_rom u_rom (
        .i_clk(i_clk), .i_reset(i_reset), .i_bus_strobe(bus_strobe),
        .i_bus_is_data(bus_is_data), .i_bus_nibble(ctrl_nibble), .o_bus_nibble(rom_nibble_out)
    );

    // mmio heads the daisy chain
    saturn_mmio u_mmio (
        .i_clk(i_clk), .i_reset(i_reset), .i_bus_strobe(bus_strobe),
        .i_bus_is_data(bus_is_data), .i_bus_nibble(ctrl_nibble), .o_bus_nibble(mmio_nibble),
        .i_daisy(1'b1), .o_daisy(mmio_daisy), .o_active(mmio_active)
    );

    saturn_sysram u_sysram (
        .i_clk(i_clk), .i_reset(i_reset), .i_bus_strobe(bus_strobe),
        .i_bus_is_data(bus_is_data), .i_bus_nibble(ctrl_nibble), .o_bus_nibble(sysram_nibble),
        .i_daisy(mmio_daisy), .o_daisy(), .o_active(sysram_active)  // end of chain
    );

endmodule

//--- rtl/saturn_mmio.sv
// ----------------------------------------------------------------------
// relocatable memory mapped io block
// 64 nibble registers, nibble 0 reads back inverted
// ----------------------------------------------------------------------
module saturn_mmio
    import saturn_bus_pkg::*;
    import saturn_map_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_bus_strobe,
    input  logic                i_bus_is_data,
    input  logic [NIBBLE_W-1:0] i_bus_nibble,
    output logic [NIBBLE_W-1:0] o_bus_nibble,
    input  logic                i_daisy,
    output logic                o_daisy,
    output logic                o_active
);

    bus_cmd_t                last_cmd;
    logic [2:0]              nib_cnt;
    logic [ADDR_W-1:0]       addr_acc;
    logic [ADDR_W-1:0]       addr_full;
    logic [ADDR_W-1:0]       ptr;
    logic [ADDR_W-1:0]       base;
    logic [ADDR_W-1:0]       offset;
    logic                    configured;
    logic                    data_stb;
    logic                    addr_last;
    logic                    cfg_take;
    logic [MMIO_IDX_W-1:0]   idx;
    logic [NIBBLE_W-1:0]     regs [MMIO_NIBBLES];

    assign data_stb  = i_bus_strobe && i_bus_is_data;
    assign addr_full = {i_bus_nibble, addr_acc[ADDR_W-1:NIBBLE_W]};
    assign addr_last = data_stb && (nib_cnt == 3'(ADDR_NIBBLES - 1));
    assign cfg_take  = addr_last && last_cmd == CMD_CONFIGURE && i_daisy && !configured;

    assign offset   = ptr - base;
    assign idx      = offset[MMIO_IDX_W-1:0];
    assign o_active = configured && (offset < ADDR_W'(MMIO_NIBBLES));
    assign o_daisy  = configured;

    // status side of register 0 shows the control side inverted
    assign o_bus_nibble = (idx == '0) ? ~regs[0] : regs[idx];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= CMD_UNCONFIG;
            nib_cnt    <= '0;
            ptr        <= '0;
            configured <= 1'b0;
        end else if (i_bus_strobe && !i_bus_is_data) begin
            last_cmd <= bus_cmd_t'(i_bus_nibble);
            nib_cnt  <= '0;
            if (bus_cmd_t'(i_bus_nibble) == CMD_UNCONFIG) configured <= 1'b0;
        end else if (data_stb) begin
            if (nib_cnt < 3'(ADDR_NIBBLES)) nib_cnt <= nib_cnt + 3'd1;
            if (addr_last && last_cmd == CMD_LOAD_ADDR) ptr <= addr_full;
            if (cfg_take) configured <= 1'b1;  // first in chain, daisy tied high
            if (last_cmd inside {CMD_DATA_READ, CMD_DATA_WRITE}) ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (data_stb) addr_acc <= addr_full;
        if (cfg_take) base <= addr_full;
        if (data_stb && last_cmd == CMD_DATA_WRITE && o_active)
            regs[idx] <= i_bus_nibble;
    end

endmodule

//--- rtl/saturn_sysram.sv
// ----------------------------------------------------------------------
// relocatable system ram
// command decoder, pointer, configure link, 256 nibble store
// ----------------------------------------------------------------------
module saturn_sysram
    import saturn_bus_pkg::*;
    import saturn_map_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_bus_strobe,
    input  logic                i_bus_is_data,
    input  logic [NIBBLE_W-1:0] i_bus_nibble,
    output logic [NIBBLE_W-1:0] o_bus_nibble,
    input  logic                i_daisy,
    output logic                o_daisy,
    output logic                o_active
);

    bus_cmd_t                  last_cmd;
    logic [2:0]                nib_cnt;
    logic [ADDR_W-1:0]         addr_acc;
    logic [ADDR_W-1:0]         addr_full;
    logic [ADDR_W-1:0]         ptr;
    logic [ADDR_W-1:0]         base;     // window start
    logic [ADDR_W-1:0]         offset;   // pointer relative to window
    logic                      configured;
    logic                      data_stb;
    logic                      addr_last;
    logic                      cfg_take; // this device claims the configure
    logic [SYSRAM_IDX_W-1:0]   idx;
    logic [NIBBLE_W-1:0]       mem [SYSRAM_NIBBLES];

    assign data_stb  = i_bus_strobe && i_bus_is_data;
    assign addr_full = {i_bus_nibble, addr_acc[ADDR_W-1:NIBBLE_W]};
    assign addr_last = data_stb && (nib_cnt == 3'(ADDR_NIBBLES - 1));
    assign cfg_take  = addr_last && last_cmd == CMD_CONFIGURE && i_daisy && !configured;

    assign offset       = ptr - base;
    assign idx          = offset[SYSRAM_IDX_W-1:0];
    assign o_active     = configured && (offset < ADDR_W'(SYSRAM_NIBBLES));
    assign o_bus_nibble = mem[idx];
    assign o_daisy      = configured;  // next in chain may configure now

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= CMD_UNCONFIG;
            nib_cnt    <= '0;
            ptr        <= '0;
            configured <= 1'b0;
        end else if (i_bus_strobe && !i_bus_is_data) begin
            last_cmd <= bus_cmd_t'(i_bus_nibble);
            nib_cnt  <= '0;
            if (bus_cmd_t'(i_bus_nibble) == CMD_UNCONFIG) configured <= 1'b0;
        end else if (data_stb) begin
            if (nib_cnt < 3'(ADDR_NIBBLES)) nib_cnt <= nib_cnt + 3'd1;
            if (addr_last && last_cmd == CMD_LOAD_ADDR) ptr <= addr_full;
            if (cfg_take) configured <= 1'b1;
            if (last_cmd inside {CMD_DATA_READ, CMD_DATA_WRITE}) ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (data_stb) addr_acc <= addr_full;
        if (cfg_take) base <= addr_full;
        if (data_stb && last_cmd == CMD_DATA_WRITE && o_active)
            mem[idx] <= i_bus_nibble;  // only inside own window
    end

endmodule

//--- rtl/saturn_rom.sv
// ----------------------------------------------------------------------
// firmware rom
// command decoder, address pointer, computed contents
// ----------------------------------------------------------------------
module saturn_rom
    import saturn_bus_pkg::*;
    import saturn_map_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_bus_strobe,
    input  logic                i_bus_is_data,
    input  logic [NIBBLE_W-1:0] i_bus_nibble,
    output logic [NIBBLE_W-1:0] o_bus_nibble
);

    bus_cmd_t          last_cmd;
    logic [2:0]        nib_cnt;    // data nibbles since last command
    logic [ADDR_W-1:0] addr_acc;   // address being assembled
    logic [ADDR_W-1:0] addr_full;
    logic [ADDR_W-1:0] ptr;
    logic              data_stb;
    logic              addr_last;  // fifth address nibble on the bus

    assign data_stb  = i_bus_strobe && i_bus_is_data;
    assign addr_full = {i_bus_nibble, addr_acc[ADDR_W-1:NIBBLE_W]};
    assign addr_last = data_stb && (nib_cnt == 3'(ADDR_NIBBLES - 1));

    assign o_bus_nibble = rom_nibble(ptr);  // always answers, mux default

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd <= CMD_UNCONFIG;
            nib_cnt  <= '0;
            ptr      <= '0;
        end else if (i_bus_strobe && !i_bus_is_data) begin
            last_cmd <= bus_cmd_t'(i_bus_nibble);
            nib_cnt  <= '0;
        end else if (data_stb) begin
            if (nib_cnt < 3'(ADDR_NIBBLES)) nib_cnt <= nib_cnt + 3'd1;
            if (addr_last && last_cmd == CMD_LOAD_ADDR) ptr <= addr_full;
            if (last_cmd inside {CMD_DATA_READ, CMD_DATA_WRITE})
                ptr <= ptr + 1'b1;  // writes just move along
        end
    end

    always_ff @(posedge i_clk)
        if (data_stb) addr_acc <= addr_full;  // lsn first, shifts down

endmodule

//--- rtl/saturn_bus_controller.sv
// ----------------------------------------------------------------------
// saturn bus controller
// host request fsm, serializes command, address and data nibbles
// ----------------------------------------------------------------------
module saturn_bus_controller
    import saturn_bus_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_bus_tick,
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  host_op_t               i_cmd_op,
    input  logic [ADDR_W-1:0]      i_cmd_addr,
    input  logic [COUNT_W-1:0]     i_cmd_count,
    input  logic [XFER_DATA_W-1:0] i_cmd_data,
    output logic                   o_rsp_valid,
    input  logic                   i_rsp_ready,
    output logic [XFER_DATA_W-1:0] o_rsp_data,
    output logic                   o_bus_strobe,
    output logic                   o_bus_is_data,
    output logic [NIBBLE_W-1:0]    o_bus_nibble,
    input  logic [NIBBLE_W-1:0]    i_bus_nibble
);

    typedef enum logic [2:0] {
        IDLE, SEND_CMD, SEND_ADDR, DATA_CMD, DATA, RESPOND
    } state_t;

    state_t                 state;
    host_op_t               op_r;     // latched request
    logic [ADDR_W-1:0]      addr_sr;  // address, shifted out lsn first
    logic [COUNT_W-1:0]     count_r;
    logic [COUNT_W-1:0]     nib_cnt;
    logic [XFER_DATA_W-1:0] data_sr;  // write data out, read data in
    logic                   moving;

    assign moving       = state inside {SEND_CMD, SEND_ADDR, DATA_CMD, DATA};
    assign o_bus_strobe = moving && i_bus_tick;  // one clock per bus cycle
    assign o_cmd_ready  = (state == IDLE);
    assign o_rsp_valid  = (state == RESPOND);
    assign o_rsp_data   = (op_r == OP_READ) ? data_sr : '0;  // others answer zero

    // nibble on the bus for the current state
    always_comb begin
        o_bus_is_data = 1'b0;
        o_bus_nibble  = '0;
        case (state)
            SEND_CMD: begin
                case (op_r)
                    OP_CONFIG:   o_bus_nibble = CMD_CONFIGURE;
                    OP_UNCONFIG: o_bus_nibble = CMD_UNCONFIG;
                    default:     o_bus_nibble = CMD_LOAD_ADDR;  // read and write
                endcase
            end
            SEND_ADDR: begin
                o_bus_is_data = 1'b1;
                o_bus_nibble  = addr_sr[NIBBLE_W-1:0];
            end
            DATA_CMD: o_bus_nibble = (op_r == OP_READ) ? CMD_DATA_READ : CMD_DATA_WRITE;
            DATA: begin
                o_bus_is_data = 1'b1;
                if (op_r == OP_WRITE) o_bus_nibble = data_sr[NIBBLE_W-1:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= IDLE;
            nib_cnt <= '0;
        end else begin
            case (state)
                IDLE: if (i_cmd_valid) state <= SEND_CMD;
                SEND_CMD: if (i_bus_tick) begin
                    state <= (op_r == OP_UNCONFIG) ? RESPOND : SEND_ADDR;  // lone nibble
                end
                SEND_ADDR: if (i_bus_tick) begin
                    if (nib_cnt == COUNT_W'(ADDR_NIBBLES - 1)) begin
                        nib_cnt <= '0;
                        state   <= (op_r == OP_CONFIG) ? RESPOND : DATA_CMD;
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end
                DATA_CMD: if (i_bus_tick) state <= DATA;
                DATA: if (i_bus_tick) begin
                    if (nib_cnt == count_r) begin
                        nib_cnt <= '0;
                        state   <= RESPOND;
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end
                RESPOND: if (i_rsp_ready) state <= IDLE;  // hold until taken
                default: state <= IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_cmd_valid) begin
            op_r    <= i_cmd_op;
            addr_sr <= i_cmd_addr;
            count_r <= i_cmd_count;
            data_sr <= (i_cmd_op == OP_WRITE) ? i_cmd_data : '0;
        end else if (state == SEND_ADDR && i_bus_tick) begin
            addr_sr <= addr_sr >> NIBBLE_W;
        end else if (state == DATA && i_bus_tick) begin
            if (op_r == OP_READ)
                data_sr[nib_cnt*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble;  // nibble k at 4k
            else
                data_sr <= data_sr >> NIBBLE_W;
        end
    end

endmodule

//--- rtl/saturn_map_pkg.sv
// ----------------------------------------------------------------------
// memory map of the bus devices
// device sizes and the computed firmware rom contents
// ----------------------------------------------------------------------
package saturn_map_pkg;

    import saturn_bus_pkg::*;

    localparam int SYSRAM_NIBBLES = 256;
    localparam int SYSRAM_IDX_W   = $clog2(SYSRAM_NIBBLES);
    localparam int MMIO_NIBBLES   = 64;
    localparam int MMIO_IDX_W     = $clog2(MMIO_NIBBLES);

    // rom content rule
    // xor of the three low address nibbles, offset by 3, wraps mod 16
    function automatic logic [NIBBLE_W-1:0] rom_nibble(input logic [ADDR_W-1:0] addr);
        logic [NIBBLE_W-1:0] mix;
        mix = addr[3:0] ^ addr[7:4] ^ addr[11:8];
        return mix + 4'd3;  // natural 4 bit wrap
    endfunction

endpackage

//--- rtl/saturn_bus_pkg.sv
// ----------------------------------------------------------------------
// saturn bus encodings and widths
// bus command nibbles, host opcodes, phase count
// ----------------------------------------------------------------------
package saturn_bus_pkg;

    // nibble bus geometry
    localparam int NIBBLE_W     = 4;
    localparam int ADDR_NIBBLES = 5;
    localparam int ADDR_W       = NIBBLE_W * ADDR_NIBBLES;  // 20 bit space

    // host transfer limits
    localparam int MAX_XFER    = 16;  // nibbles per request
    localparam int XFER_DATA_W = NIBBLE_W * MAX_XFER;
    localparam int COUNT_W     = $clog2(MAX_XFER);  // holds count minus one

    // bus cycle
    localparam int PHASES  = 4;
    localparam int PHASE_W = $clog2(PHASES);
    localparam int CYCLE_W = 32;

    // command nibbles, sent with is_data low
    typedef enum logic [NIBBLE_W-1:0] {
        CMD_DATA_WRITE = 4'h1,  // devices take data nibbles
        CMD_DATA_READ  = 4'h3,  // devices drive data nibbles
        CMD_LOAD_ADDR  = 4'h5,  // five address nibbles follow, lsn first
        CMD_CONFIGURE  = 4'h8,  // five base nibbles for first free device
        CMD_UNCONFIG   = 4'h9   // everybody drops its window
    } bus_cmd_t;

    // host side requests
    typedef enum logic [1:0] {
        OP_READ     = 2'd0,
        OP_WRITE    = 2'd1,
        OP_CONFIG   = 2'd2,
        OP_UNCONFIG = 2'd3
    } host_op_t;

endpackage
